/* sources.f */
verilog/core_pkg.sv
verilog/fetch_bus_if.sv
verilog/issue_bus_if.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_control.sv
verilog/id_stage.sv
verilog/ex_stage.sv
verilog/core_top.sv
sim/tb_core.sv

/* sim/tb_core.sv */
`timescale 1ns/1ns

module tb_core;

    logic clk;
    logic rst_n;
    logic imem_we;
    logic [core_pkg::imem_addr_w-1:0] imem_addr;
    logic [core_pkg::xlen-1:0] imem_wdata;
    logic wb_valid;
    logic [core_pkg::reg_addr_w-1:0] wb_rd;
    logic [core_pkg::xlen-1:0] wb_data;

    integer seed;
    logic [31:0] prog [core_pkg::imem_depth];
    int prog_len;
    logic program_ready = 1'b0;
    logic [4:0] exp_rd_q [$]; // In-order write-backs from the model
    logic [31:0] exp_data_q [$];
    int cycles_after_reset;

    core_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // RV32I encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, 3'b000, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111}; // LUI
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic append_word(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // Registers x0..x7 only so dependencies come often
    task automatic pick_alu_inst(output logic [31:0] word);
        logic [31:0] r;
        r = $random(seed);
        case (r[10:9])
            2'd0: word = r_type(7'h00, 5'(r[8:6]), 5'(r[5:3]), 5'(r[2:0]));
            2'd1: word = r_type(7'h20, 5'(r[8:6]), 5'(r[5:3]), 5'(r[2:0]));
            2'd2: word = i_type(r[31:20], 5'(r[5:3]), 5'(r[2:0]), 7'b0010011);
            default: word = u_type(r[31:12], 5'(r[2:0]));
        endcase
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] word;
        int base;
        prog_len = 0;
        for (int i = 1; i < 8; i++) begin
            r = $random(seed);
            append_word(u_type(r[31:12], 5'(i)));
            append_word(i_type({1'b1, r[10:0]}, 5'(i), 5'(i), 7'b0010011)); // Negative imm
        end
        for (int round = 0; round < 2; round++) begin
            repeat (10) begin
                pick_alu_inst(word);
                append_word(word);
            end
            append_word(r_type(7'h00, 5'd2, 5'd1, 5'd0)); // Result dropped at x0
            r = $random(seed);
            append_word({r[31:7], 7'b0001011}); // Custom opcode that decodes as a no-op
            append_word(r_type(7'h20, 5'd4, 5'd0, 5'd3)); // x3 = 0 - x4
            append_word(j_type(21'd8, 5'd5));
            append_word(i_type(12'd1, 5'd6, 5'd6, 7'b0010011)); // Wrong path
            base = prog_len;
            // Odd target so JALR has to drop bit 0
            append_word(i_type(12'(4 * (base + 3) + 1), 5'd0, 5'd7, 7'b0010011));
            append_word(i_type(12'd0, 5'd7, 5'd1, 7'b1100111));
            append_word(i_type(12'd1, 5'd2, 5'd2, 7'b0010011)); // Wrong path
        end
        append_word(j_type(21'd0, 5'd0)); // Parks the core
    endtask

    // In-order ISA model stepping one instruction at a time
    task automatic run_reference_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] imm_i;
        logic [31:0] imm_j;
        logic [31:0] result;
        logic [31:0] next_pc;
        logic writes;
        logic halted;
        int steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        halted = 1'b0;
        steps = 0;
        while (!halted) begin
            inst = prog[pc[7:2]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            writes = 1'b0;
            result = '0;
            next_pc = pc + 32'd4;
            case (inst[6:0])
                core_pkg::op: begin
                    writes = inst[14:12] == 3'b000 &&
                             (inst[31:25] == 7'h00 || inst[31:25] == 7'h20);
                    result = inst[30] ? regs[inst[19:15]] - regs[inst[24:20]]
                                      : regs[inst[19:15]] + regs[inst[24:20]];
                end
                core_pkg::op_imm: begin
                    writes = inst[14:12] == 3'b000;
                    result = regs[inst[19:15]] + imm_i;
                end
                core_pkg::lui: begin
                    writes = 1'b1;
                    result = {inst[31:12], 12'b0};
                end
                core_pkg::jal: begin
                    writes = 1'b1;
                    result = pc + 32'd4;
                    next_pc = pc + imm_j;
                    halted = imm_j == '0;
                end
                core_pkg::jalr: begin
                    if (inst[14:12] == 3'b000) begin
                        writes = 1'b1;
                        result = pc + 32'd4;
                        next_pc = (regs[inst[19:15]] + imm_i) & ~32'd1;
                    end
                end
                default: ;
            endcase
            if (writes && inst[11:7] != 5'd0) begin
                regs[inst[11:7]] = result;
                exp_rd_q.push_back(inst[11:7]);
                exp_data_q.push_back(result);
            end
            pc = next_pc;
            steps++;
            if (steps > 4 * prog_len) begin
                abort_run("Reference model never reached the final self jump");
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n || cycles_after_reset < 2) begin
            assert (wb_valid === 1'b0)
            else abort_run("A write-back appeared during reset or right after it");
        end else if (wb_valid !== 1'b0) begin
            assert (exp_rd_q.size() != 0) begin
                assert (wb_rd === exp_rd_q[0] && wb_data === exp_data_q[0]) begin
                    void'(exp_rd_q.pop_front());
                    void'(exp_data_q.pop_front());
                end else begin
                    abort_run($sformatf("Mismatch at time %0t: got x%0d = %h, expected x%0d = %h",
                                        $time, wb_rd, wb_data, exp_rd_q[0], exp_data_q[0]));
                end
            end else begin
                abort_run("A write-back appeared after all expected write-backs were seen");
            end
        end
        if (!rst_n) begin
            cycles_after_reset = 0;
        end else if (cycles_after_reset < 2) begin
            cycles_after_reset++;
        end
    end

    initial begin
        wait (program_ready);
        repeat (8 + 3 * prog_len + 50) @(posedge clk);
        abort_run("Timeout: the core did not finish the program in time");
    end

    initial begin
        rst_n = 1'b0;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_wdata = '0;
        seed = 96518;
        build_program();
        run_reference_model();
        program_ready = 1'b1;
        // Program goes in while the core sits in reset
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            #1;
            imem_we = 1'b1;
            imem_addr = core_pkg::imem_addr_w'(i);
            imem_wdata = prog[i];
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (exp_rd_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk); // Core is parked so any stray write-back shows here
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* verilog/core_top.sv */
`timescale 1ns/1ns

module core_top (
    input logic clk,
    input logic rst_n,
    input logic imem_we,
    input logic [core_pkg::imem_addr_w-1:0] imem_addr,
    input logic [core_pkg::xlen-1:0] imem_wdata,
    output logic wb_valid,
    output logic [core_pkg::reg_addr_w-1:0] wb_rd,
    output logic [core_pkg::xlen-1:0] wb_data
);

    logic redirect;
    logic [core_pkg::xlen-1:0] redirect_target;
    logic [core_pkg::reg_addr_w-1:0] ra1;
    logic [core_pkg::reg_addr_w-1:0] ra2;
    logic [core_pkg::xlen-1:0] rd1;
    logic [core_pkg::xlen-1:0] rd2;

    fetch_bus_if fetch_bus ();
    issue_bus_if issue_bus ();

    fetch_stage fetch_stage (
        .clk(clk), .rst_n(rst_n),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .redirect(redirect), .redirect_target(redirect_target),

        .bus(fetch_bus.source)
    );

    id_stage id_stage (
        .clk(clk), .rst_n(rst_n),
        .fetch(fetch_bus.sink),
        .wb_en(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .rd1(rd1), .rd2(rd2),

        .ra1(ra1), .ra2(ra2),
        .redirect(redirect), .redirect_target(redirect_target),
        .issue(issue_bus.source)
    );

    reg_file reg_file (
        .clk(clk), .rst_n(rst_n),
        .ra1(ra1), .ra2(ra2),
        .we(wb_valid), .wa(wb_rd), .wd(wb_data),

        .rd1(rd1), .rd2(rd2)
    );

    ex_stage ex_stage (
        .issue(issue_bus.sink),

        .wb_en(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

/* verilog/ex_stage.sv */
`timescale 1ns/1ns

module ex_stage (
    issue_bus_if.sink issue,
    output logic wb_en,
    output logic [core_pkg::reg_addr_w-1:0] wb_rd,
    output logic [core_pkg::xlen-1:0] wb_data
);

    logic [core_pkg::xlen-1:0] result;

    always_comb begin
        case (issue.alu_op)
            core_pkg::add: result = issue.op_a + issue.op_b;
            core_pkg::sub: result = issue.op_a - issue.op_b;
            core_pkg::pass_b: result = issue.op_b;
            core_pkg::link: result = issue.pc + core_pkg::xlen'(4); // Return address
            default: result = issue.op_a + issue.op_b;
        endcase
    end

    // Written back on the next edge
    assign wb_en = issue.valid;
    assign wb_rd = issue.rd;
    assign wb_data = result;

endmodule

/* verilog/id_stage.sv */
`timescale 1ns/1ns

module id_stage (
    input logic clk,
    input logic rst_n,
    fetch_bus_if.sink fetch,
    input logic wb_en, // Execute result valid this cycle
    input logic [core_pkg::reg_addr_w-1:0] wb_rd,
    input logic [core_pkg::xlen-1:0] wb_data,
    input logic [core_pkg::xlen-1:0] rd1,
    input logic [core_pkg::xlen-1:0] rd2,
    output logic [core_pkg::reg_addr_w-1:0] ra1,
    output logic [core_pkg::reg_addr_w-1:0] ra2,
    output logic redirect,
    output logic [core_pkg::xlen-1:0] redirect_target,
    issue_bus_if.source issue
);

    core_pkg::alu_op_e alu_op;
    core_pkg::imm_kind_e imm_kind;
    logic use_imm;
    logic writes_rd;
    logic is_jal;
    logic is_jalr;
    logic [core_pkg::reg_addr_w-1:0] rd;
    logic [core_pkg::xlen-1:0] imm;
    logic [core_pkg::xlen-1:0] rs1_val;
    logic [core_pkg::xlen-1:0] rs2_val;
    logic [core_pkg::xlen-1:0] jalr_sum;

    assign ra1 = fetch.inst[19:15];
    assign ra2 = fetch.inst[24:20];
    assign rd = fetch.inst[11:7];

    decode_control control (
        .inst(fetch.inst),

        .alu_op(alu_op), .imm_kind(imm_kind), .use_imm(use_imm),
        .writes_rd(writes_rd), .is_jal(is_jal), .is_jalr(is_jalr)
    );

    always_comb begin
        case (imm_kind)
            core_pkg::imm_u: imm = {fetch.inst[31:12], 12'b0};
            core_pkg::imm_j: imm = {{12{fetch.inst[31]}}, fetch.inst[19:12], fetch.inst[20],
                                    fetch.inst[30:21], 1'b0};
            default: imm = {{20{fetch.inst[31]}}, fetch.inst[31:20]};
        endcase
    end

    // Bypass from execute; wb_en never rises for an x0 destination
    assign rs1_val = (wb_en && wb_rd == ra1) ? wb_data : rd1;
    assign rs2_val = (wb_en && wb_rd == ra2) ? wb_data : rd2;

    assign jalr_sum = rs1_val + imm;
    assign redirect = fetch.valid && (is_jal || is_jalr);
    assign redirect_target = is_jalr ? {jalr_sum[core_pkg::xlen-1:1], 1'b0}
                                     : fetch.pc + imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= fetch.valid && writes_rd && rd != '0; // Drop no-ops early
        end
    end

    always_ff @(posedge clk) begin
        issue.pc <= fetch.pc;
        issue.alu_op <= alu_op;
        issue.rd <= rd;
        issue.op_a <= rs1_val;
        issue.op_b <= use_imm ? imm : rs2_val;
    end

endmodule

/* verilog/decode_control.sv */
`timescale 1ns/1ns

module decode_control (
    input logic [core_pkg::xlen-1:0] inst,
    output core_pkg::alu_op_e alu_op,
    output core_pkg::imm_kind_e imm_kind,
    output logic use_imm,
    output logic writes_rd,
    output logic is_jal,
    output logic is_jalr
);

    core_pkg::opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = core_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        // Defaults describe a no-op
        alu_op = core_pkg::add;
        imm_kind = core_pkg::imm_i;
        use_imm = 1'b0;
        writes_rd = 1'b0;
        is_jal = 1'b0;
        is_jalr = 1'b0;
        case (opcode)
            core_pkg::op: begin
                // Only ADD and SUB are implemented
                if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
                    alu_op = funct7[5] ? core_pkg::sub : core_pkg::add;
                    writes_rd = 1'b1;
                end
            end
            core_pkg::op_imm: begin
                if (funct3 == 3'b000) begin // ADDI
                    use_imm = 1'b1;
                    writes_rd = 1'b1;
                end
            end
            core_pkg::lui: begin
                alu_op = core_pkg::pass_b;
                imm_kind = core_pkg::imm_u;
                use_imm = 1'b1;
                writes_rd = 1'b1;
            end
            core_pkg::jal: begin
                alu_op = core_pkg::link;
                imm_kind = core_pkg::imm_j;
                writes_rd = 1'b1;
                is_jal = 1'b1;
            end
            core_pkg::jalr: begin
                if (funct3 == 3'b000) begin
                    alu_op = core_pkg::link;
                    writes_rd = 1'b1;
                    is_jalr = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input logic clk,
    input logic rst_n,
    input logic [core_pkg::reg_addr_w-1:0] ra1,
    input logic [core_pkg::reg_addr_w-1:0] ra2,
    input logic we,
    input logic [core_pkg::reg_addr_w-1:0] wa,
    input logic [core_pkg::xlen-1:0] wd,
    output logic [core_pkg::xlen-1:0] rd1,
    output logic [core_pkg::xlen-1:0] rd2
);

    logic [core_pkg::xlen-1:0] regs [1 << core_pkg::reg_addr_w];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << core_pkg::reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin // x0 stays zero
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input logic clk,
    input logic rst_n,
    input logic imem_we,
    input logic [core_pkg::imem_addr_w-1:0] imem_addr,
    input logic [core_pkg::xlen-1:0] imem_wdata,
    input logic redirect,
    input logic [core_pkg::xlen-1:0] redirect_target,
    fetch_bus_if.source bus
);

    logic [core_pkg::xlen-1:0] imem [core_pkg::imem_depth];
    logic [core_pkg::xlen-1:0] pc;
    logic [core_pkg::xlen-1:0] pc_next;
    logic [core_pkg::xlen-1:0] inst;

    // Program load port, usable at any time
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign inst = imem[pc[core_pkg::imem_addr_w+1:2]]; // Async read, word aligned

    // Jump from decode wins over sequential fetch
    assign pc_next = redirect ? redirect_target : pc + core_pkg::xlen'(4);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
            bus.valid <= 1'b0;
        end else begin
            pc <= pc_next;
            // Word fetched alongside a redirect is on the wrong path
            bus.valid <= !redirect;
        end
    end

    always_ff @(posedge clk) begin
        bus.pc <= pc;
        bus.inst <= inst;
    end

endmodule

/* verilog/issue_bus_if.sv */
`timescale 1ns/1ns

interface issue_bus_if;

    // Low for no-ops and x0 writes
    logic valid;
    logic [core_pkg::xlen-1:0] pc;
    core_pkg::alu_op_e alu_op;
    logic [core_pkg::reg_addr_w-1:0] rd;
    logic [core_pkg::xlen-1:0] op_a; // Forwarded rs1
    logic [core_pkg::xlen-1:0] op_b; // Immediate or forwarded rs2

    modport source (
        output valid, pc, alu_op, rd,
        output op_a, op_b
    );

    modport sink (
        input valid, pc, alu_op, rd,
        input op_a, op_b
    );

endinterface

/* verilog/fetch_bus_if.sv */
`timescale 1ns/1ns

interface fetch_bus_if;

    logic valid; // Holds an instruction to decode this cycle
    logic [core_pkg::xlen-1:0] pc;
    logic [core_pkg::xlen-1:0] inst;

    modport source (
        output valid,
        output pc,
        output inst
    );

    modport sink (
        input valid,
        input pc,
        input inst
    );

endinterface

/* verilog/core_pkg.sv */
package core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int imem_depth = 64;
    localparam int imem_addr_w = 6; // Word address into imem

    // Major opcodes handled by this core
    typedef enum logic [6:0] {
        op     = 7'b0110011, // ADD, SUB
        op_imm = 7'b0010011, // ADDI
        lui    = 7'b0110111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111
    } opcode_e;

    // Operation performed in execute
    typedef enum logic [1:0] {
        add    = 2'd0,
        sub    = 2'd1,
        pass_b = 2'd2, // LUI result is the immediate itself
        link   = 2'd3  // Return address for JAL/JALR
    } alu_op_e;

    // Immediate formats needed by the supported instructions
    typedef enum logic [1:0] {
        imm_i = 2'd0,
        imm_u = 2'd1,
        imm_j = 2'd2
    } imm_kind_e;

endpackage
